/* hdl/read_guard_pkg.sv */
/*
 * AXI read watchdog shared definitions
 * Pool size, field widths, index and counter types, phase and fault encodings
 */
package read_guard_pkg;

  // Reads tracked at once
  localparam int unsigned NumSlots     = 4;
  localparam int unsigned SlotIdxWidth = $clog2(NumSlots);

  // AXI field widths
  localparam int unsigned IdWidth      = 4;
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned LenWidth     = 8;

  // Interval counters and budgets
  localparam int unsigned CntWidth     = 16;

  typedef logic [SlotIdxWidth-1:0] slot_idx_t;
  typedef logic [IdWidth-1:0]      id_t;
  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [LenWidth-1:0]     len_t;
  typedef logic [CntWidth-1:0]     cnt_t;

  // Life of one tracked read
  typedef enum logic [1:0] {
    PHASE_IDLE,
    PHASE_ADDR,
    PHASE_DATA
  } txn_phase_e;

  // Reason for the last watchdog trip
  typedef enum logic [2:0] {
    FAULT_NONE,
    FAULT_AR_WAIT,
    FAULT_FIRST_DATA,
    FAULT_R_STALL,
    FAULT_BURST,
    FAULT_UNWANTED
  } fault_e;

endpackage

/* hdl/slot_if.sv */
/*
 * Slot events from the ID order queue to the transaction timers
 * Allocation of a new read, R beat lookup and retirement of a finished read
 */
`timescale 1ns/10ps

interface slot_if;

  // New read accepted into alloc_slot
  logic                      alloc;
  read_guard_pkg::slot_idx_t alloc_slot;
  read_guard_pkg::id_t       alloc_id;
  read_guard_pkg::addr_t     alloc_addr;
  read_guard_pkg::len_t      alloc_len;

  // R beat sampled and the head slot of its ID
  logic                      beat;
  logic                      beat_hit;
  read_guard_pkg::slot_idx_t beat_slot;

  // Last beat handshaked, slot done
  logic                      retire;
  read_guard_pkg::slot_idx_t retire_slot;

  modport queue (
    output alloc, alloc_slot, alloc_id, alloc_addr, alloc_len,
    output beat, beat_hit, beat_slot,
    output retire, retire_slot
  );

  modport timer (
    input alloc, alloc_slot, alloc_id, alloc_addr, alloc_len,
    input beat, beat_hit, beat_slot,
    input retire, retire_slot
  );

endinterface

/* hdl/id_order_queue.sv */
/*
 * ID order queue
 * Keeps a linked list of slots per live AXI ID so reads of one ID retire in order,
 * allocates slots on AR handshakes and resolves R beats to the head slot of their ID
 */
`timescale 1ns/10ps

module id_order_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  ar_valid_i,
  input  logic                  ar_ready_i,
  input  read_guard_pkg::id_t   ar_id_i,
  input  read_guard_pkg::addr_t ar_addr_i,
  input  read_guard_pkg::len_t  ar_len_i,
  input  logic                  r_valid_i,
  input  logic                  r_ready_i,
  input  read_guard_pkg::id_t   r_id_i,
  input  logic                  r_last_i,
  input  logic                  tracking_off_i,
  output logic                  full_o,
  output logic                  unwanted_o,
  slot_if.queue                 slot
);

  // Slot pool and per-slot link to the next read of the same ID
  logic [read_guard_pkg::NumSlots-1:0]                            slot_free_q, slot_free_d;
  read_guard_pkg::slot_idx_t [read_guard_pkg::NumSlots-1:0]       next_q, next_d;

  // Head-tail table, one entry per live ID, never more entries than slots
  logic [read_guard_pkg::NumSlots-1:0]                            ht_vld_q, ht_vld_d;
  read_guard_pkg::id_t [read_guard_pkg::NumSlots-1:0]             ht_id_q, ht_id_d;
  read_guard_pkg::slot_idx_t [read_guard_pkg::NumSlots-1:0]       ht_head_q, ht_head_d;
  read_guard_pkg::slot_idx_t [read_guard_pkg::NumSlots-1:0]       ht_tail_q, ht_tail_d;

  logic                                accept, retire, rsp_empties;
  logic                                rsp_hit, in_hit;
  read_guard_pkg::slot_idx_t           rsp_idx, in_idx, rsp_head;
  logic [read_guard_pkg::NumSlots-1:0] slot_free_now, ht_free_now;
  read_guard_pkg::slot_idx_t           new_slot, new_ht;

  assign full_o = (slot_free_q == '0);
  assign accept = ar_valid_i && ar_ready_i && !full_o && !tracking_off_i;

  // Table lookup for the R beat ID and the incoming AR ID
  always_comb begin
    rsp_hit = 1'b0;
    rsp_idx = '0;
    in_hit  = 1'b0;
    in_idx  = '0;
    for (int i = 0; i < read_guard_pkg::NumSlots; i++) begin
      if (ht_vld_q[i] && (ht_id_q[i] == r_id_i)) begin
        rsp_hit = 1'b1;
        rsp_idx = read_guard_pkg::slot_idx_t'(i);
      end
      if (ht_vld_q[i] && (ht_id_q[i] == ar_id_i)) begin
        in_hit = 1'b1;
        in_idx = read_guard_pkg::slot_idx_t'(i);
      end
    end
  end

  assign rsp_head    = ht_head_q[rsp_idx];
  assign retire      = r_valid_i && r_ready_i && r_last_i && rsp_hit;
  assign rsp_empties = retire && (rsp_head == ht_tail_q[rsp_idx]);
  assign unwanted_o  = r_valid_i && !rsp_hit;

  // Lowest free slot and table entry, counting those freed this cycle
  always_comb begin
    slot_free_now = slot_free_q;
    ht_free_now   = ~ht_vld_q;
    if (retire) begin
      slot_free_now[rsp_head] = 1'b1;
    end
    if (rsp_empties) begin
      ht_free_now[rsp_idx] = 1'b1;
    end
    new_slot = '0;
    new_ht   = '0;
    for (int i = read_guard_pkg::NumSlots - 1; i >= 0; i--) begin
      if (slot_free_now[i]) begin
        new_slot = read_guard_pkg::slot_idx_t'(i);
      end
      if (ht_free_now[i]) begin
        new_ht = read_guard_pkg::slot_idx_t'(i);
      end
    end
  end

  always_comb begin
    slot_free_d = slot_free_q;
    next_d      = next_q;
    ht_vld_d    = ht_vld_q;
    ht_id_d     = ht_id_q;
    ht_head_d   = ht_head_q;
    ht_tail_d   = ht_tail_q;
    // Pop the head of the responding ID
    if (retire) begin
      slot_free_d[rsp_head] = 1'b1;
      if (rsp_empties) begin
        ht_vld_d[rsp_idx] = 1'b0;
      end else begin
        ht_head_d[rsp_idx] = next_q[rsp_head];
      end
    end
    // Append to a live chain, or open a new one if the ID has none left
    if (accept) begin
      slot_free_d[new_slot] = 1'b0;
      if (in_hit && !(rsp_empties && (rsp_idx == in_idx))) begin
        next_d[ht_tail_q[in_idx]] = new_slot;
        ht_tail_d[in_idx]         = new_slot;
      end else begin
        ht_vld_d[new_ht]  = 1'b1;
        ht_id_d[new_ht]   = ar_id_i;
        ht_head_d[new_ht] = new_slot;
        ht_tail_d[new_ht] = new_slot;
      end
    end
    // Flush everything while the watchdog holds its reset request
    if (tracking_off_i) begin
      slot_free_d = '1;
      ht_vld_d    = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_free_q <= '1;
      ht_vld_q    <= '0;
    end else begin
      slot_free_q <= slot_free_d;
      ht_vld_q    <= ht_vld_d;
    end
  end

  always_ff @(posedge clk_i) begin
    next_q    <= next_d;
    ht_id_q   <= ht_id_d;
    ht_head_q <= ht_head_d;
    ht_tail_q <= ht_tail_d;
  end

  assign slot.alloc       = accept;
  assign slot.alloc_slot  = new_slot;
  assign slot.alloc_id    = ar_id_i;
  assign slot.alloc_addr  = ar_addr_i;
  assign slot.alloc_len   = ar_len_i;
  assign slot.beat        = r_valid_i;
  assign slot.beat_hit    = r_valid_i && rsp_hit;
  assign slot.beat_slot   = rsp_head;
  assign slot.retire      = retire;
  assign slot.retire_slot = rsp_head;

  // A chain head always points at an occupied slot
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    retire |-> !slot_free_q[rsp_head]);

  // The pool fills only through an accepted read
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(full_o) |-> $past(accept));

endmodule

/* hdl/txn_timer.sv */
/*
 * Transaction timers
 * Per-slot phase machines with first-data, R stall and burst counters,
 * a shared AR wait counter and budget checks with fixed fault priority
 */
`timescale 1ns/10ps

module txn_timer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ar_valid_i,
  input  logic                   ar_ready_i,
  input  logic                   r_ready_i,
  input  read_guard_pkg::cnt_t   budget_ar_i,
  input  read_guard_pkg::cnt_t   budget_first_i,
  input  read_guard_pkg::cnt_t   budget_stall_i,
  input  read_guard_pkg::cnt_t   budget_beat_i,
  input  logic                   tracking_off_i,
  output logic                   fault_o,
  output read_guard_pkg::fault_e fault_cause_o,
  output read_guard_pkg::id_t    fault_id_o,
  output read_guard_pkg::addr_t  fault_addr_o,
  output logic                   first_lat_vld_o,
  output read_guard_pkg::cnt_t   first_lat_o,
  output logic                   burst_lat_vld_o,
  output read_guard_pkg::cnt_t   burst_lat_o,
  slot_if.timer                  slot
);

  read_guard_pkg::txn_phase_e phase_q     [read_guard_pkg::NumSlots];
  read_guard_pkg::id_t        id_q        [read_guard_pkg::NumSlots];
  read_guard_pkg::addr_t      addr_q      [read_guard_pkg::NumSlots];
  read_guard_pkg::len_t       len_q       [read_guard_pkg::NumSlots];
  read_guard_pkg::cnt_t       first_cnt_q [read_guard_pkg::NumSlots];
  read_guard_pkg::cnt_t       stall_cnt_q [read_guard_pkg::NumSlots];
  read_guard_pkg::cnt_t       burst_cnt_q [read_guard_pkg::NumSlots];

  // Only the read not yet accepted waits on AR, so one counter serves all
  read_guard_pkg::cnt_t       ar_cnt_q;

  logic [read_guard_pkg::NumSlots-1:0]                        hit;
  logic [read_guard_pkg::CntWidth+read_guard_pkg::LenWidth:0] burst_budget;
  read_guard_pkg::fault_e                                     slot_cause;

  // Beat aimed at each slot
  always_comb begin
    for (int i = 0; i < read_guard_pkg::NumSlots; i++) begin
      hit[i] = slot.beat && slot.beat_hit && (slot.beat_slot == i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < read_guard_pkg::NumSlots; i++) begin
        phase_q[i] <= read_guard_pkg::PHASE_IDLE;
      end
      ar_cnt_q        <= '0;
      first_lat_vld_o <= 1'b0;
      burst_lat_vld_o <= 1'b0;
    end else begin
      first_lat_vld_o <= 1'b0;
      burst_lat_vld_o <= 1'b0;
      for (int i = 0; i < read_guard_pkg::NumSlots; i++) begin
        if (!tracking_off_i && hit[i] && (phase_q[i] == read_guard_pkg::PHASE_ADDR)) begin
          first_lat_vld_o <= 1'b1;
        end
        if (!tracking_off_i && slot.retire && (slot.retire_slot == i)) begin
          burst_lat_vld_o <= 1'b1;
        end
        // A new read may take over a slot in the cycle it retires
        if (tracking_off_i) begin
          phase_q[i] <= read_guard_pkg::PHASE_IDLE;
        end else if (slot.alloc && (slot.alloc_slot == i)) begin
          phase_q[i] <= read_guard_pkg::PHASE_ADDR;
        end else if (slot.retire && (slot.retire_slot == i)) begin
          phase_q[i] <= read_guard_pkg::PHASE_IDLE;
        end else if (hit[i] && (phase_q[i] == read_guard_pkg::PHASE_ADDR)) begin
          phase_q[i] <= read_guard_pkg::PHASE_DATA;
        end
      end
      if (tracking_off_i || (ar_valid_i && ar_ready_i)) begin
        ar_cnt_q <= '0;
      end else if (ar_valid_i) begin
        ar_cnt_q <= ar_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < read_guard_pkg::NumSlots; i++) begin
      if (slot.alloc && (slot.alloc_slot == i)) begin
        id_q[i]        <= slot.alloc_id;
        addr_q[i]      <= slot.alloc_addr;
        len_q[i]       <= slot.alloc_len;
        first_cnt_q[i] <= '0;
        stall_cnt_q[i] <= '0;
        burst_cnt_q[i] <= '0;
      end else begin
        if (phase_q[i] == read_guard_pkg::PHASE_ADDR) begin
          first_cnt_q[i] <= first_cnt_q[i] + 1'b1;
        end
        if (phase_q[i] == read_guard_pkg::PHASE_DATA) begin
          burst_cnt_q[i] <= burst_cnt_q[i] + 1'b1;
        end
        if (hit[i] && !r_ready_i) begin
          stall_cnt_q[i] <= stall_cnt_q[i] + 1'b1;
        end
      end
      if (hit[i] && (phase_q[i] == read_guard_pkg::PHASE_ADDR)) begin
        first_lat_o <= first_cnt_q[i];
      end
      if (slot.retire && (slot.retire_slot == i)) begin
        burst_lat_o <= burst_cnt_q[i];
      end
    end
  end

  // AR wait has the lowest rank and carries no ID or address
  always_comb begin
    fault_o       = (ar_cnt_q > budget_ar_i);
    fault_cause_o = fault_o ? read_guard_pkg::FAULT_AR_WAIT : read_guard_pkg::FAULT_NONE;
    fault_id_o    = '0;
    fault_addr_o  = '0;
    burst_budget  = '0;
    slot_cause    = read_guard_pkg::FAULT_NONE;
    // Walk down so the lowest slot overrides, and the first cause within a slot
    for (int i = read_guard_pkg::NumSlots - 1; i >= 0; i--) begin
      burst_budget = {{(read_guard_pkg::LenWidth + 1){1'b0}}, budget_beat_i} *
                     ({{(read_guard_pkg::CntWidth + 1){1'b0}}, len_q[i]} + 1'b1);
      slot_cause   = read_guard_pkg::FAULT_NONE;
      if ((phase_q[i] == read_guard_pkg::PHASE_DATA) &&
          ({{(read_guard_pkg::LenWidth + 1){1'b0}}, burst_cnt_q[i]} > burst_budget)) begin
        slot_cause = read_guard_pkg::FAULT_BURST;
      end
      if ((phase_q[i] != read_guard_pkg::PHASE_IDLE) && (stall_cnt_q[i] > budget_stall_i)) begin
        slot_cause = read_guard_pkg::FAULT_R_STALL;
      end
      if ((phase_q[i] == read_guard_pkg::PHASE_ADDR) && (first_cnt_q[i] > budget_first_i)) begin
        slot_cause = read_guard_pkg::FAULT_FIRST_DATA;
      end
      if (slot_cause != read_guard_pkg::FAULT_NONE) begin
        fault_o       = 1'b1;
        fault_cause_o = slot_cause;
        fault_id_o    = id_q[i];
        fault_addr_o  = addr_q[i];
      end
    end
  end

  // Queue chains and timer phases stay in step
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    slot.beat_hit |-> (phase_q[slot.beat_slot] != read_guard_pkg::PHASE_IDLE));

endmodule

/* hdl/fault_reporter.sv */
/*
 * Fault reporter
 * Latches the first fault record, pulses the interrupt, holds the reset request
 * until software clears it and keeps the latest latency values
 */
`timescale 1ns/10ps

module fault_reporter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   tmr_fault_i,
  input  read_guard_pkg::fault_e tmr_cause_i,
  input  read_guard_pkg::id_t    tmr_id_i,
  input  read_guard_pkg::addr_t  tmr_addr_i,
  input  logic                   unwanted_i,
  input  read_guard_pkg::id_t    r_id_i,
  input  logic                   reset_clear_i,
  input  logic                   first_lat_vld_i,
  input  read_guard_pkg::cnt_t   first_lat_i,
  input  logic                   burst_lat_vld_i,
  input  read_guard_pkg::cnt_t   burst_lat_i,
  output logic                   reset_req_o,
  output logic                   irq_o,
  output read_guard_pkg::fault_e fault_cause_o,
  output read_guard_pkg::id_t    fault_id_o,
  output read_guard_pkg::addr_t  fault_addr_o,
  output read_guard_pkg::cnt_t   lat_first_o,
  output read_guard_pkg::cnt_t   lat_burst_o
);

  logic new_fault;

  // Faults are ignored while a reset request is pending
  assign new_fault = (tmr_fault_i || unwanted_i) && !reset_req_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reset_req_o   <= 1'b0;
      irq_o         <= 1'b0;
      fault_cause_o <= read_guard_pkg::FAULT_NONE;
      lat_first_o   <= '0;
      lat_burst_o   <= '0;
    end else begin
      irq_o <= new_fault;
      if (new_fault) begin
        reset_req_o   <= 1'b1;
        fault_cause_o <= tmr_fault_i ? tmr_cause_i : read_guard_pkg::FAULT_UNWANTED;
      end else if (reset_clear_i) begin
        reset_req_o <= 1'b0;
      end
      if (first_lat_vld_i) begin
        lat_first_o <= first_lat_i;
      end
      if (burst_lat_vld_i) begin
        lat_burst_o <= burst_lat_i;
      end
    end
  end

  // Timer faults win, an unwanted beat has no address
  always_ff @(posedge clk_i) begin
    if (new_fault) begin
      fault_id_o   <= tmr_fault_i ? tmr_id_i : r_id_i;
      fault_addr_o <= tmr_fault_i ? tmr_addr_i : '0;
    end
  end

  // One interrupt per trip
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_o |=> !irq_o);

endmodule

/* hdl/read_guard.sv */
/*
 * AXI read-channel watchdog
 * Tracks outstanding reads per ID, times them against budgets and
 * reports the first overrun or unexpected response
 */
`timescale 1ns/10ps

module read_guard (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ar_valid_i,
  input  logic                   ar_ready_i,
  input  read_guard_pkg::id_t    ar_id_i,
  input  read_guard_pkg::addr_t  ar_addr_i,
  input  read_guard_pkg::len_t   ar_len_i,
  input  logic                   r_valid_i,
  input  logic                   r_ready_i,
  input  read_guard_pkg::id_t    r_id_i,
  input  logic                   r_last_i,
  input  read_guard_pkg::cnt_t   budget_ar_i,
  input  read_guard_pkg::cnt_t   budget_first_i,
  input  read_guard_pkg::cnt_t   budget_stall_i,
  input  read_guard_pkg::cnt_t   budget_beat_i,
  input  logic                   reset_clear_i,
  output logic                   full_o,
  output logic                   reset_req_o,
  output logic                   irq_o,
  output read_guard_pkg::fault_e fault_cause_o,
  output read_guard_pkg::id_t    fault_id_o,
  output read_guard_pkg::addr_t  fault_addr_o,
  output read_guard_pkg::cnt_t   lat_first_o,
  output read_guard_pkg::cnt_t   lat_burst_o
);

  logic                   unwanted;
  logic                   tmr_fault;
  read_guard_pkg::fault_e tmr_cause;
  read_guard_pkg::id_t    tmr_id;
  read_guard_pkg::addr_t  tmr_addr;
  logic                   first_lat_vld, burst_lat_vld;
  read_guard_pkg::cnt_t   first_lat, burst_lat;

  slot_if i_slot ();

  id_order_queue i_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ar_valid_i     (ar_valid_i),
    .ar_ready_i     (ar_ready_i),
    .ar_id_i        (ar_id_i),
    .ar_addr_i      (ar_addr_i),
    .ar_len_i       (ar_len_i),
    .r_valid_i      (r_valid_i),
    .r_ready_i      (r_ready_i),
    .r_id_i         (r_id_i),
    .r_last_i       (r_last_i),
    .tracking_off_i (reset_req_o),
    .full_o         (full_o),
    .unwanted_o     (unwanted),
    .slot           (i_slot)
  );

  txn_timer i_timer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ar_valid_i      (ar_valid_i),
    .ar_ready_i      (ar_ready_i),
    .r_ready_i       (r_ready_i),
    .budget_ar_i     (budget_ar_i),
    .budget_first_i  (budget_first_i),
    .budget_stall_i  (budget_stall_i),
    .budget_beat_i   (budget_beat_i),
    .tracking_off_i  (reset_req_o),
    .fault_o         (tmr_fault),
    .fault_cause_o   (tmr_cause),
    .fault_id_o      (tmr_id),
    .fault_addr_o    (tmr_addr),
    .first_lat_vld_o (first_lat_vld),
    .first_lat_o     (first_lat),
    .burst_lat_vld_o (burst_lat_vld),
    .burst_lat_o     (burst_lat),
    .slot            (i_slot)
  );

  fault_reporter i_reporter (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .tmr_fault_i     (tmr_fault),
    .tmr_cause_i     (tmr_cause),
    .tmr_id_i        (tmr_id),
    .tmr_addr_i      (tmr_addr),
    .unwanted_i      (unwanted),
    .r_id_i          (r_id_i),
    .reset_clear_i   (reset_clear_i),
    .first_lat_vld_i (first_lat_vld),
    .first_lat_i     (first_lat),
    .burst_lat_vld_i (burst_lat_vld),
    .burst_lat_i     (burst_lat),
    .reset_req_o     (reset_req_o),
    .irq_o           (irq_o),
    .fault_cause_o   (fault_cause_o),
    .fault_id_o      (fault_id_o),
    .fault_addr_o    (fault_addr_o),
    .lat_first_o     (lat_first_o),
    .lat_burst_o     (lat_burst_o)
  );

endmodule

/* bench/read_guard_cases.svh */
/*
 * Scenario table for the read watchdog testbench
 * One row per scenario with traffic shape, budgets and expected fault record
 */

localparam int NumCases = 7;

// name, kind, id_a, id_b, addr, len, nreads, ar_wait, first_delay, stall,
// budget ar/first/stall/beat, expected cause, id, addr and irq count
case_t cases [NumCases] = '{
  '{"clean_read", KindClean, 3, 0, 'h1000, 3, 1, 1, 2, 0,
    8, 6, 3, 4, read_guard_pkg::FAULT_NONE, 0, 0, 0},
  '{"per_id_order", KindOrder, 1, 2, 'h2000, 1, 4, 0, 1, 0,
    10, 200, 3, 4, read_guard_pkg::FAULT_NONE, 0, 0, 0},
  '{"first_data_overrun", KindFault, 6, 0, 'h3000, 1, 1, 0, 9, 0,
    8, 4, 3, 4, read_guard_pkg::FAULT_FIRST_DATA, 6, 'h3000, 1},
  '{"r_stall_overrun", KindFault, 7, 0, 'h4000, 2, 1, 0, 1, 5,
    8, 6, 2, 4, read_guard_pkg::FAULT_R_STALL, 7, 'h4000, 1},
  '{"ar_wait_overrun", KindFault, 8, 0, 'h5000, 0, 1, 6, 1, 0,
    2, 6, 3, 4, read_guard_pkg::FAULT_AR_WAIT, 0, 0, 1},
  '{"unwanted_beat", KindUnwanted, 9, 0, 0, 0, 0, 0, 0, 0,
    8, 6, 3, 4, read_guard_pkg::FAULT_UNWANTED, 9, 0, 1},
  // Timeout first, then the stale beat of the flushed read
  '{"flush_stale_beat", KindFlush, 5, 0, 'h6000, 0, 1, 0, 8, 0,
    8, 3, 3, 4, read_guard_pkg::FAULT_UNWANTED, 5, 0, 2}
};

/* bench/read_guard_tb.sv */
/*
 * Testbench for the AXI read watchdog
 * Applies a table of read scenarios and checks fault records, latencies and full
 */
`timescale 1ns/10ps

module read_guard_tb;

  localparam int KindClean    = 0;
  localparam int KindOrder    = 1;
  localparam int KindFault    = 2;
  localparam int KindUnwanted = 3;
  localparam int KindFlush    = 4;

  typedef struct {
    string name;
    int    kind;
    int    id_a;
    int    id_b;
    int    addr;
    int    len;
    int    nreads;
    int    ar_wait;
    int    first_delay;
    int    stall;
    int    b_ar;
    int    b_first;
    int    b_stall;
    int    b_beat;
    int    exp_cause;
    int    exp_id;
    int    exp_addr;
    int    exp_irqs;
  } case_t;

  `include "read_guard_cases.svh"

  logic                   clk_i, rst_ni;
  logic                   ar_valid, ar_ready, r_valid, r_ready, r_last, reset_clear;
  read_guard_pkg::id_t    ar_id, r_id;
  read_guard_pkg::addr_t  ar_addr;
  read_guard_pkg::len_t   ar_len;
  read_guard_pkg::cnt_t   budget_ar, budget_first, budget_stall, budget_beat;
  logic                   full, reset_req, irq;
  read_guard_pkg::fault_e fault_cause;
  read_guard_pkg::id_t    fault_id;
  read_guard_pkg::addr_t  fault_addr;
  read_guard_pkg::cnt_t   lat_first, lat_burst;

  integer seed = 32'h900e_092b;
  int     errors = 0;
  int     checks = 0;
  int     irq_cycles = 0;
  int     cycles = 0;
  int     cycle_limit = 0;

  // Edges from the first sampled beat to the last beat, both included
  int     burst_edges = 0;

  read_guard i_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ar_valid_i     (ar_valid),
    .ar_ready_i     (ar_ready),
    .ar_id_i        (ar_id),
    .ar_addr_i      (ar_addr),
    .ar_len_i       (ar_len),
    .r_valid_i      (r_valid),
    .r_ready_i      (r_ready),
    .r_id_i         (r_id),
    .r_last_i       (r_last),
    .budget_ar_i    (budget_ar),
    .budget_first_i (budget_first),
    .budget_stall_i (budget_stall),
    .budget_beat_i  (budget_beat),
    .reset_clear_i  (reset_clear),
    .full_o         (full),
    .reset_req_o    (reset_req),
    .irq_o          (irq),
    .fault_cause_o  (fault_cause),
    .fault_id_o     (fault_id),
    .fault_addr_o   (fault_addr),
    .lat_first_o    (lat_first),
    .lat_burst_o    (lat_burst)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Interrupt cycles seen in the current scenario
  always @(negedge clk_i) begin
    if (irq) begin
      irq_cycles++;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the scenarios did not finish", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic check_equal(input string name, input string what, input int exp,
                             input int act);
    checks++;
    assert (exp == act) else begin
      errors++;
      $display("[FAIL] %s %s expected 0x%0h actual 0x%0h", name, what, exp, act);
    end
  endtask

  task automatic issue_read(input int id, input int addr, input int len, input int wait_cycles);
    ar_valid = 1'b1;
    ar_ready = 1'b0;
    ar_id    = read_guard_pkg::id_t'(id);
    ar_addr  = read_guard_pkg::addr_t'(addr);
    ar_len   = read_guard_pkg::len_t'(len);
    repeat (wait_cycles) @(negedge clk_i);
    ar_ready = 1'b1;
    @(negedge clk_i);
    ar_valid = 1'b0;
    ar_ready = 1'b0;
  endtask

  // Random pauses between beats, stall cycles on the first beat only
  task automatic send_burst(input int id, input int len, input int stall);
    int pause;
    burst_edges = 0;
    for (int b = 0; b <= len; b++) begin
      if (b > 0) begin
        pause = {$random(seed)} % 3;
        repeat (pause) begin
          @(negedge clk_i);
          burst_edges++;
        end
      end
      r_valid = 1'b1;
      r_id    = read_guard_pkg::id_t'(id);
      r_last  = (b == len);
      r_ready = 1'b0;
      if (b == 0) begin
        repeat (stall) begin
          @(negedge clk_i);
          burst_edges++;
        end
      end
      r_ready = 1'b1;
      @(negedge clk_i);
      burst_edges++;
      // Bus idle during the pause
      r_valid = 1'b0;
      r_last  = 1'b0;
      r_ready = 1'b0;
    end
  endtask

  task automatic wait_reset_req(input string name);
    int n;
    n = 0;
    while (!reset_req && n < 30) begin
      @(negedge clk_i);
      n++;
    end
    checks++;
    assert (reset_req) else begin
      errors++;
      $display("%s: the reset request never rose after the fault", name);
    end
  endtask

  // Request must hold until software clears it
  task automatic hold_and_clear(input string name);
    repeat (3) @(negedge clk_i);
    check_equal(name, "reset_req held", 1, int'(reset_req));
    reset_clear = 1'b1;
    @(negedge clk_i);
    reset_clear = 1'b0;
    check_equal(name, "reset_req cleared", 0, int'(reset_req));
  endtask

  task automatic run_case(input case_t c);
    int outstanding;
    budget_ar    = read_guard_pkg::cnt_t'(c.b_ar);
    budget_first = read_guard_pkg::cnt_t'(c.b_first);
    budget_stall = read_guard_pkg::cnt_t'(c.b_stall);
    budget_beat  = read_guard_pkg::cnt_t'(c.b_beat);
    irq_cycles   = 0;
    @(negedge clk_i);
    case (c.kind)
      KindClean, KindFault: begin
        issue_read(c.id_a, c.addr, c.len, c.ar_wait);
        repeat (c.first_delay) @(negedge clk_i);
        send_burst(c.id_a, c.len, c.stall);
      end
      KindOrder: begin
        outstanding = 0;
        for (int k = 0; k < c.nreads; k++) begin
          issue_read((k < 2) ? c.id_a : c.id_b, c.addr + k * 64, c.len, c.ar_wait);
          outstanding++;
          check_equal(c.name, "full_o", int'(outstanding == read_guard_pkg::NumSlots),
                      int'(full));
        end
        repeat (c.first_delay) @(negedge clk_i);
        // Interleave the two IDs, each retiring its oldest read
        for (int k = 0; k < c.nreads; k++) begin
          send_burst((k % 2 == 0) ? c.id_a : c.id_b, c.len, 0);
          outstanding--;
          check_equal(c.name, "full_o", int'(outstanding == read_guard_pkg::NumSlots),
                      int'(full));
        end
      end
      KindUnwanted: begin
        send_burst(c.id_a, c.len, 0);
      end
      KindFlush: begin
        issue_read(c.id_a, c.addr, c.len, c.ar_wait);
        repeat (c.first_delay) @(negedge clk_i);
        wait_reset_req(c.name);
        hold_and_clear(c.name);
        send_burst(c.id_a, c.len, 0);
      end
      default: begin
        $display("%s: unknown scenario kind %0d", c.name, c.kind);
        errors++;
      end
    endcase
    if (c.exp_cause == read_guard_pkg::FAULT_NONE) begin
      repeat (2) @(negedge clk_i);
      check_equal(c.name, "reset_req", 0, int'(reset_req));
      check_equal(c.name, "cause", c.exp_cause, int'(fault_cause));
    end else begin
      wait_reset_req(c.name);
      check_equal(c.name, "cause", c.exp_cause, int'(fault_cause));
      check_equal(c.name, "fault id", c.exp_id, int'(fault_id));
      check_equal(c.name, "fault addr", c.exp_addr, int'(fault_addr));
      hold_and_clear(c.name);
    end
    if (c.kind == KindClean) begin
      check_equal(c.name, "first latency", c.first_delay, int'(lat_first));
      // Burst counts the edges strictly between the first and the last beat
      check_equal(c.name, "burst latency", (burst_edges > 1) ? burst_edges - 2 : 0,
                  int'(lat_burst));
      checks++;
      assert (int'(lat_burst) <= c.b_beat * (c.len + 1)) else begin
        errors++;
        $display("[FAIL] %s burst latency expected at most %0d actual %0d",
                 c.name, c.b_beat * (c.len + 1), lat_burst);
      end
    end
    repeat (2) @(negedge clk_i);
    check_equal(c.name, "irq cycles", c.exp_irqs, irq_cycles);
  endtask

  initial begin
    int limit;
    rst_ni       = 1'b0;
    ar_valid     = 1'b0;
    ar_ready     = 1'b0;
    ar_id        = '0;
    ar_addr      = '0;
    ar_len       = '0;
    r_valid      = 1'b0;
    r_ready      = 1'b0;
    r_id         = '0;
    r_last       = 1'b0;
    reset_clear  = 1'b0;
    budget_ar    = '0;
    budget_first = '0;
    budget_stall = '0;
    budget_beat  = '0;
    // Delays plus beats with worst pauses, and a margin per row
    limit = 20;
    foreach (cases[i]) begin
      limit += cases[i].ar_wait + cases[i].first_delay + cases[i].stall +
               cases[i].nreads * (cases[i].len + 1) * 3 + 20;
    end
    cycle_limit = limit;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    check_equal("reset", "reset_req", 0, int'(reset_req));
    check_equal("reset", "irq", 0, int'(irq));
    check_equal("reset", "full", 0, int'(full));
    check_equal("reset", "lat_first", 0, int'(lat_first));
    check_equal("reset", "lat_burst", 0, int'(lat_burst));
    check_equal("reset", "cause", read_guard_pkg::FAULT_NONE, int'(fault_cause));
    foreach (cases[i]) begin
      run_case(cases[i]);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+bench
hdl/read_guard_pkg.sv
hdl/slot_if.sv
hdl/id_order_queue.sv
hdl/txn_timer.sv
hdl/fault_reporter.sv
hdl/read_guard.sv
bench/read_guard_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the read watchdog testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module read_guard_tb \
  -f all.f

output=$(./obj_dir/Vread_guard_tb)
echo "$output"

# Verdict comes from the testbench's own pass line
echo "$output" | grep -q '^\*\* PASS \*\*$'
echo "Simulation passed"
